//--- src/core_pkg.sv
// shared types for the load/store path
// the data bus width is fixed at 32 bits, so byte enables are 4 bits wide
// the dtype code 2'b11 is unused and is decoded as a word access

package core_pkg;

    // data bus width, one word
    localparam int XLEN = 32;

    // access size from the core
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_dtype_t;

    // OBI master states
    // IDLE        ready for a core request, OBI request driven straight from it
    // REQUESTING  captured request replayed until the grant
    // WAITING     granted, waiting for rvalid
    // HOLDING     response held until the core takes it
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        REQUESTING = 2'b01,
        WAITING    = 2'b10,
        HOLDING    = 2'b11
    } obi_state_t;

endpackage

//--- src/lsu_align.sv
// byte lane alignment between the core and the OBI word bus
// request side is combinational from the core inputs
// load side uses offset, size and sign mode captured on req_accept_i
// raw_rdata_i must be zero for writes and errors, which then give zero data

`timescale 1ns/1ps

module lsu_align #(
    parameter int ADDR_W = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // request from the core
    input  logic [ADDR_W-1:0]        core_addr_i,
    input  core_pkg::mem_dtype_t     core_dtype_i,
    input  logic                     core_unsigned_i,
    input  logic [core_pkg::XLEN-1:0] core_wdata_i,
    input  logic                     req_accept_i,

    // aligned request towards the controller
    output logic [3:0]               req_be_o,
    output logic [core_pkg::XLEN-1:0] req_wdata_o,
    output logic                     misaligned_o,

    // load path
    input  logic [core_pkg::XLEN-1:0] raw_rdata_i,
    output logic [core_pkg::XLEN-1:0] resp_rdata_o
);
    import core_pkg::*;

    logic [1:0]      offset;
    logic [1:0]      off_q;
    mem_dtype_t      dtype_q;
    logic            unsigned_q;
    logic [XLEN-1:0] shifted;

    // byte offset inside the word
    assign offset = core_addr_i[1:0];

    // byte enables, write lanes and misalignment
    always_comb begin
        req_be_o     = 4'b1111;
        req_wdata_o  = core_wdata_i;
        misaligned_o = 1'b0;
        case (core_dtype_i)
            BYTE: begin
                req_be_o    = 4'b0001 << offset;
                // byte copied to every lane, be picks the one
                req_wdata_o = {4{core_wdata_i[7:0]}};
            end
            HALF: begin
                req_be_o     = 4'b0011 << offset;
                // offset 3 would cross the word boundary
                misaligned_o = (offset == 2'd3);
                if (offset[0]) begin
                    // odd offset, halfword lands in lanes 1 and 2
                    req_wdata_o = {core_wdata_i[7:0], core_wdata_i[15:0], core_wdata_i[15:8]};
                end else begin
                    req_wdata_o = {2{core_wdata_i[15:0]}};
                end
            end
            default: begin
                // word, only offset 0 allowed
                req_be_o     = 4'b1111;
                misaligned_o = (offset != 2'd0);
            end
        endcase
    end

    // load info kept for the response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            off_q      <= 2'd0;
            dtype_q    <= WORD;
            unsigned_q <= 1'b0;
        end else if (req_accept_i) begin
            off_q      <= offset;
            dtype_q    <= core_dtype_i;
            unsigned_q <= core_unsigned_i;
        end
    end

    // addressed lane moved down to bit 0
    assign shifted = raw_rdata_i >> {off_q, 3'b000};

    // sign or zero extension
    always_comb begin
        case (dtype_q)
            BYTE:    resp_rdata_o = {{(XLEN-8){~unsigned_q & shifted[7]}}, shifted[7:0]};
            HALF:    resp_rdata_o = {{(XLEN-16){~unsigned_q & shifted[15]}}, shifted[15:0]};
            default: resp_rdata_o = raw_rdata_i;
        endcase
    end

endmodule

//--- src/obi_controller.sv
// OBI master for one outstanding transaction
// assumes rvalid is returned after the grant, never in the grant cycle
// response is held until resp_ready_i, no new request is taken meanwhile
// misaligned requests complete with an error and no bus transfer
// atomics are not supported, obi_atop_o is tied to zero

`timescale 1ns/1ps

module obi_controller #(
    parameter int ADDR_W = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // core request
    input  logic                      core_valid_i,
    output logic                      core_ready_o,
    input  logic [ADDR_W-1:0]         core_addr_i,
    input  logic                      core_we_i,

    // aligned request from lsu_align
    input  logic [3:0]                req_be_i,
    input  logic [core_pkg::XLEN-1:0] req_wdata_i,
    input  logic                      misaligned_i,
    output logic                      req_accept_o,

    // response to the core
    output logic                      resp_valid_o,
    input  logic                      resp_ready_i,
    output logic [core_pkg::XLEN-1:0] raw_rdata_o,
    output logic                      resp_err_o,

    // OBI master
    output logic                      obi_req_o,
    input  logic                      obi_gnt_i,
    output logic [ADDR_W-1:0]         obi_addr_o,
    output logic                      obi_we_o,
    output logic [3:0]                obi_be_o,
    output logic [core_pkg::XLEN-1:0] obi_wdata_o,
    output logic [5:0]                obi_atop_o,
    input  logic                      obi_rvalid_i,
    input  logic [core_pkg::XLEN-1:0] obi_rdata_i,
    input  logic                      obi_err_i
);
    import core_pkg::*;

    obi_state_t        state_q;
    obi_state_t        state_d;

    // captured request, word address only
    logic [ADDR_W-1:2] addr_q;
    logic              we_q;
    logic [3:0]        be_q;
    logic [XLEN-1:0]   wdata_q;

    // held response
    logic [XLEN-1:0]   rdata_q;
    logic              err_q;

    assign obi_atop_o   = 6'b000000;
    assign resp_valid_o = (state_q == HOLDING);
    assign raw_rdata_o  = rdata_q;
    assign resp_err_o   = err_q;

    always_comb begin
        state_d      = state_q;
        core_ready_o = 1'b0;
        req_accept_o = 1'b0;
        obi_req_o    = 1'b0;
        // replay from the capture registers by default
        obi_addr_o   = {addr_q, 2'b00};
        obi_we_o     = we_q;
        obi_be_o     = be_q;
        obi_wdata_o  = wdata_q;
        case (state_q)
            IDLE: begin
                core_ready_o = 1'b1;
                req_accept_o = core_valid_i;
                // bus sees the core request in the same cycle
                obi_req_o    = core_valid_i & ~misaligned_i;
                obi_addr_o   = {core_addr_i[ADDR_W-1:2], 2'b00};
                obi_we_o     = core_we_i;
                obi_be_o     = req_be_i;
                obi_wdata_o  = req_wdata_i;
                if (core_valid_i) begin
                    if (misaligned_i) begin
                        state_d = HOLDING;
                    end else if (obi_gnt_i) begin
                        state_d = WAITING;
                    end else begin
                        state_d = REQUESTING;
                    end
                end
            end
            REQUESTING: begin
                obi_req_o = 1'b1;
                if (obi_gnt_i) begin
                    state_d = WAITING;
                end
            end
            WAITING: begin
                if (obi_rvalid_i) begin
                    state_d = HOLDING;
                end
            end
            default: begin
                // HOLDING, wait for the core to take it
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request capture on acceptance
    always_ff @(posedge clk) begin
        if (req_accept_o) begin
            addr_q  <= core_addr_i[ADDR_W-1:2];
            we_q    <= core_we_i;
            be_q    <= req_be_i;
            wdata_q <= req_wdata_i;
        end
    end

    // response register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else if (state_q == IDLE && core_valid_i && misaligned_i) begin
            // error without touching the bus
            rdata_q <= '0;
            err_q   <= 1'b1;
        end else if (state_q == WAITING && obi_rvalid_i) begin
            // writes return no data
            rdata_q <= we_q ? '0 : obi_rdata_i;
            err_q   <= obi_err_i;
        end
    end

endmodule

//--- src/obi_sram.sv
// single-port OBI memory model, one-cycle read latency
// grant drops whenever bit 0 of an 8-bit LFSR is set, STALL_SEED must be nonzero
// addresses at or beyond MEM_WORDS*4 give an error and zero data
// assumes MEM_WORDS is a power of two and fits the address width

`timescale 1ns/1ps

module obi_sram #(
    parameter int          ADDR_W     = 32,
    parameter int          MEM_WORDS  = 256,
    parameter logic [7:0]  STALL_SEED = 8'hA5
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      obi_req_i,
    output logic                      obi_gnt_o,
    input  logic [ADDR_W-1:0]         obi_addr_i,
    input  logic                      obi_we_i,
    input  logic [3:0]                obi_be_i,
    input  logic [core_pkg::XLEN-1:0] obi_wdata_i,
    output logic                      obi_rvalid_o,
    output logic [core_pkg::XLEN-1:0] obi_rdata_o,
    output logic                      obi_err_o
);
    import core_pkg::*;

    localparam int                IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam logic [ADDR_W:0]   LIMIT = (ADDR_W + 1)'(MEM_WORDS * 4);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [7:0]       lfsr_q;
    logic             fire;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // x^8 + x^6 + x^5 + x^4 + 1, shifted left every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= STALL_SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign obi_gnt_o = ~lfsr_q[0];
    assign fire      = obi_req_i & obi_gnt_o;
    assign in_range  = ({1'b0, obi_addr_i} < LIMIT);
    assign idx       = obi_addr_i[IDX_W+1:2];

    // storage, byte-wise writes on a granted in-range request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (fire && obi_we_i && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (obi_be_i[b]) begin
                    mem[idx][8*b +: 8] <= obi_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // response phase, one cycle after the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obi_rvalid_o <= 1'b0;
            obi_err_o    <= 1'b0;
        end else begin
            obi_rvalid_o <= fire;
            obi_err_o    <= fire & ~in_range;
        end
    end

    // read data, zero for writes and out of range
    always_ff @(posedge clk) begin
        if (fire) begin
            obi_rdata_o <= (in_range && !obi_we_i) ? mem[idx] : '0;
        end
    end

endmodule

//--- src/lsu_top.sv
// load/store unit with its OBI memory model
// one transaction at a time, the response is held until resp_ready_i
// atomics are not modelled, the atop output of the controller is left open

`timescale 1ns/1ps

module lsu_top #(
    parameter int         ADDR_W     = 32,
    parameter int         MEM_WORDS  = 256,
    parameter logic [7:0] STALL_SEED = 8'hA5
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // core request
    input  logic                      core_valid_i,
    output logic                      core_ready_o,
    input  logic [ADDR_W-1:0]         core_addr_i,
    input  logic                      core_we_i,
    input  core_pkg::mem_dtype_t      core_dtype_i,
    input  logic                      core_unsigned_i,
    input  logic [core_pkg::XLEN-1:0] core_wdata_i,

    // core response
    output logic                      resp_valid_o,
    input  logic                      resp_ready_i,
    output logic [core_pkg::XLEN-1:0] resp_rdata_o,
    output logic                      resp_err_o
);
    import core_pkg::*;

    // align <-> controller
    logic [3:0]        req_be;
    logic [XLEN-1:0]   req_wdata;
    logic              misaligned;
    logic              req_accept;
    logic [XLEN-1:0]   raw_rdata;

    // OBI bus
    logic              obi_req;
    logic              obi_gnt;
    logic [ADDR_W-1:0] obi_addr;
    logic              obi_we;
    logic [3:0]        obi_be;
    logic [XLEN-1:0]   obi_wdata;
    logic              obi_rvalid;
    logic [XLEN-1:0]   obi_rdata;
    logic              obi_err;

    lsu_align #(
        .ADDR_W (ADDR_W)
    ) u_align (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_addr_i     (core_addr_i),
        .core_dtype_i    (core_dtype_i),
        .core_unsigned_i (core_unsigned_i),
        .core_wdata_i    (core_wdata_i),
        .req_accept_i    (req_accept),
        .req_be_o        (req_be),
        .req_wdata_o     (req_wdata),
        .misaligned_o    (misaligned),
        .raw_rdata_i     (raw_rdata),
        .resp_rdata_o    (resp_rdata_o)
    );

    obi_controller #(
        .ADDR_W (ADDR_W)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_valid_i (core_valid_i),
        .core_ready_o (core_ready_o),
        .core_addr_i  (core_addr_i),
        .core_we_i    (core_we_i),
        .req_be_i     (req_be),
        .req_wdata_i  (req_wdata),
        .misaligned_i (misaligned),
        .req_accept_o (req_accept),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .raw_rdata_o  (raw_rdata),
        .resp_err_o   (resp_err_o),
        .obi_req_o    (obi_req),
        .obi_gnt_i    (obi_gnt),
        .obi_addr_o   (obi_addr),
        .obi_we_o     (obi_we),
        .obi_be_o     (obi_be),
        .obi_wdata_o  (obi_wdata),
        // memory has no atomics
        .obi_atop_o   (),
        .obi_rvalid_i (obi_rvalid),
        .obi_rdata_i  (obi_rdata),
        .obi_err_i    (obi_err)
    );

    obi_sram #(
        .ADDR_W     (ADDR_W),
        .MEM_WORDS  (MEM_WORDS),
        .STALL_SEED (STALL_SEED)
    ) u_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .obi_req_i    (obi_req),
        .obi_gnt_o    (obi_gnt),
        .obi_addr_i   (obi_addr),
        .obi_we_i     (obi_we),
        .obi_be_i     (obi_be),
        .obi_wdata_i  (obi_wdata),
        .obi_rvalid_o (obi_rvalid),
        .obi_rdata_o  (obi_rdata),
        .obi_err_o    (obi_err)
    );

endmodule

//--- sim/tb_clock.sv
// clock and reset source for the testbench
// reset is released on a falling edge, away from the rising edge

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // low for RESET_CYCLES rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- sim/tb_lsu_top.sv
// random load/store traffic checked against a byte model of the memory
// inputs change on the falling edge and outputs are sampled 1 ns later
// MEM_WORDS here is also given to the DUT so model and memory agree

`timescale 1ns/1ps

module tb_lsu_top;
    import core_pkg::*;

    localparam int         ADDR_W     = 32;
    localparam int         MEM_WORDS  = 256;
    localparam logic [7:0] STALL_SEED = 8'h5B;
    localparam int         MEM_BYTES  = MEM_WORDS * 4;
    localparam int         BYTE_W     = $clog2(MEM_BYTES);
    localparam int         NUM_TXN    = 400;
    localparam int         TIMEOUT    = 200;

    logic              clk;
    logic              rst_n;
    logic              core_valid_i;
    logic              core_ready_o;
    logic [ADDR_W-1:0] core_addr_i;
    logic              core_we_i;
    mem_dtype_t        core_dtype_i;
    logic              core_unsigned_i;
    logic [XLEN-1:0]   core_wdata_i;
    logic              resp_valid_o;
    logic              resp_ready_i;
    logic [XLEN-1:0]   resp_rdata_o;
    logic              resp_err_o;

    // byte image of the memory
    logic [7:0]        model_mem [MEM_BYTES];
    integer            seed;
    int                errors;
    int                timeouts;
    int                n_done;
    int                n_err_resp;
    logic              hung;
    // expectation for the transaction in flight
    logic [ADDR_W-1:0] txn_addr;
    logic [XLEN-1:0]   exp_rdata;
    logic              exp_err;

    tb_clock #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    lsu_top #(
        .ADDR_W     (ADDR_W),
        .MEM_WORDS  (MEM_WORDS),
        .STALL_SEED (STALL_SEED)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_valid_i    (core_valid_i),
        .core_ready_o    (core_ready_o),
        .core_addr_i     (core_addr_i),
        .core_we_i       (core_we_i),
        .core_dtype_i    (core_dtype_i),
        .core_unsigned_i (core_unsigned_i),
        .core_wdata_i    (core_wdata_i),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .resp_rdata_o    (resp_rdata_o),
        .resp_err_o      (resp_err_o)
    );

    task automatic expect_value(input string what, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] want);
        assert (got === want) else begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h (addr %h)",
                     $time, what, got, want, txn_addr);
        end
    endtask

    // little endian with the lowest byte at the access address
    function automatic void store_model(input logic [BYTE_W-1:0] ba, input mem_dtype_t dt,
                                        input logic [XLEN-1:0] wd);
        model_mem[ba] = wd[7:0];
        if (dt != BYTE) begin
            model_mem[ba + BYTE_W'(1)] = wd[15:8];
        end
        if (dt == WORD) begin
            model_mem[ba + BYTE_W'(2)] = wd[23:16];
            model_mem[ba + BYTE_W'(3)] = wd[31:24];
        end
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [BYTE_W-1:0] ba,
                                                   input mem_dtype_t dt, input logic uns);
        logic [XLEN-1:0] v;
        case (dt)
            BYTE: begin
                v = {24'd0, model_mem[ba]};
                if (!uns && v[7]) begin
                    v[31:8] = '1;
                end
            end
            HALF: begin
                v = {16'd0, model_mem[ba + BYTE_W'(1)], model_mem[ba]};
                if (!uns && v[15]) begin
                    v[31:16] = '1;
                end
            end
            // sign mode has no effect on a full word
            default: v = {model_mem[ba + BYTE_W'(3)], model_mem[ba + BYTE_W'(2)],
                          model_mem[ba + BYTE_W'(1)], model_mem[ba]};
        endcase
        return v;
    endfunction

    // expected response of the accepted request and model update for stores
    task automatic predict;
        logic [BYTE_W-1:0] ba;
        logic              bad;
        ba        = core_addr_i[BYTE_W-1:0];
        txn_addr  = core_addr_i;
        bad       = (core_dtype_i == HALF && core_addr_i[1:0] == 2'd3) ||
                    (core_dtype_i == WORD && core_addr_i[1:0] != 2'd0);
        exp_err   = bad || (core_addr_i >= MEM_BYTES);
        exp_rdata = '0;
        if (!exp_err) begin
            if (core_we_i) begin
                store_model(ba, core_dtype_i, core_wdata_i);
            end else begin
                exp_rdata = load_value(ba, core_dtype_i, core_unsigned_i);
            end
        end
    endtask

    task automatic random_request;
        logic [31:0] r;
        logic [31:0] pick;
        r    = $random(seed);
        pick = {$random(seed)} % 8;
        if (pick == 0) begin
            // beyond the memory either just above it or high up
            core_addr_i = r[31] ? {1'b1, r[30:0]} : 32'(MEM_BYTES) + 32'(r[9:0]);
        end else if (pick < 3) begin
            core_addr_i = 32'(r[BYTE_W-1:0]);
        end else begin
            // small window so loads often hit earlier stores
            core_addr_i = 32'(r[5:0]);
        end
        pick            = {$random(seed)} % 3;
        core_dtype_i    = mem_dtype_t'(pick[1:0]);
        r               = $random(seed);
        core_we_i       = r[0];
        core_unsigned_i = r[1];
        core_wdata_i    = $random(seed);
    endtask

    task automatic run_transaction;
        int              cycles;
        int              stall;
        logic [XLEN-1:0] held_rdata;
        logic            held_err;
        @(negedge clk);
        random_request();
        core_valid_i = 1'b1;
        resp_ready_i = 1'b0;
        #1;
        cycles = 0;
        while (!core_ready_o && cycles < TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!core_ready_o) begin
            $display("request handshake never completed by %0t", $time);
            timeouts++;
            hung = 1'b1;
            return;
        end
        // valid and ready both high so taken at the next rising edge
        predict();
        @(negedge clk);
        core_valid_i = 1'b0;
        // new junk on the request lines since the DUT works from its captured copy
        random_request();
        #1;
        cycles = 0;
        while (!resp_valid_o && cycles < TIMEOUT) begin
            expect_value("core_ready_o in flight", 32'(core_ready_o), 32'(0));
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!resp_valid_o) begin
            $display("response handshake never completed by %0t", $time);
            timeouts++;
            hung = 1'b1;
            return;
        end
        expect_value("resp_err_o", 32'(resp_err_o), 32'(exp_err));
        expect_value("resp_rdata_o", resp_rdata_o, exp_rdata);
        held_rdata = resp_rdata_o;
        held_err   = resp_err_o;
        // response must not move under back-pressure
        stall = {$random(seed)} % 4;
        repeat (stall) begin
            @(negedge clk);
            #1;
            expect_value("resp_valid_o held", 32'(resp_valid_o), 32'(1));
            expect_value("resp_rdata_o held", resp_rdata_o, held_rdata);
            expect_value("resp_err_o held", 32'(resp_err_o), 32'(held_err));
            expect_value("core_ready_o held", 32'(core_ready_o), 32'(0));
        end
        @(negedge clk);
        resp_ready_i = 1'b1;
        @(negedge clk);
        resp_ready_i = 1'b0;
        #1;
        // exactly one response and then back to idle
        expect_value("resp_valid_o after take", 32'(resp_valid_o), 32'(0));
        expect_value("core_ready_o after take", 32'(core_ready_o), 32'(1));
        n_done++;
        if (exp_err) begin
            n_err_resp++;
        end
    endtask

    initial begin
        int cycles;
        seed            = 47;
        errors          = 0;
        timeouts        = 0;
        n_done          = 0;
        n_err_resp      = 0;
        hung            = 1'b0;
        txn_addr        = '0;
        exp_rdata       = '0;
        exp_err         = 1'b0;
        core_valid_i    = 1'b0;
        core_addr_i     = '0;
        core_we_i       = 1'b0;
        core_dtype_i    = BYTE;
        core_unsigned_i = 1'b0;
        core_wdata_i    = '0;
        resp_ready_i    = 1'b0;
        // memory comes out of reset cleared
        model_mem       = '{default: 8'h00};

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            timeouts++;
        end else begin
            expect_value("resp_valid_o after reset", 32'(resp_valid_o), 32'(0));
            expect_value("core_ready_o after reset", 32'(core_ready_o), 32'(1));
            for (int i = 0; i < NUM_TXN && !hung; i++) begin
                run_transaction();
            end
        end

        $display("errors: %0d, timeouts: %0d, transactions: %0d, error responses: %0d",
                 errors, timeouts, n_done, n_err_resp);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
src/core_pkg.sv
src/lsu_align.sv
src/obi_controller.sv
src/obi_sram.sv
src/lsu_top.sv
sim/tb_clock.sv
sim/tb_lsu_top.sv

//--- run_sim.sh
#!/bin/sh
# build the LSU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu_top \
    -f flist.f \
    -Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_lsu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
